// File: list.f
+incdir+logic
logic/dcache_types_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_ctrl_if.sv
logic/dcache_control.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_bus_port.sv
logic/dcache.sv
verification/dcache_sva.sv
verification/dcache_tb.sv

// File: logic/dcache.sv
// the processor must hold its request until dhit; halt is only honoured with no miss pending
`default_nettype none

module dcache import dcache_types_pkg::*; (
    input  logic  CLK,
    input  logic  nRST,
    input  logic  dmemren,
    input  logic  dmemwen,
    input  logic  halt,
    input  word_t dmemaddr,
    input  word_t dmemstore,
    input  word_t mem_load,
    input  logic  mem_wait,
    output word_t dmemload,
    output word_t mem_addr,
    output word_t mem_store,
    output logic  dhit,
    output logic  flushed,
    output logic  mem_ren,
    output logic  mem_wen
);

    dc_addr_t req_addr;
    dc_tag_t  victim_tag, slot_tag;
    word_t    victim_data, slot_data;

    assign req_addr = dc_addr_t'(dmemaddr);

    dcache_ctrl_if ctl_if ();

    dcache_control u_control (
        .CLK, .nRST, .dmemren, .dmemwen, .halt, .mem_wait,
        .ctl     (ctl_if.ctrl),
        .mem_ren, .mem_wen, .flushed
    );

    dcache_tag_array u_tags (
        .CLK, .nRST, .dmemren, .dmemwen,
        .addr       (req_addr),
        .dp         (ctl_if.datapath),
        .victim_tag, .slot_tag
    );

    dcache_data_array u_data (
        .CLK, .nRST, .dmemwen, .dmemstore, .mem_load,
        .addr        (req_addr),
        .dp          (ctl_if.datapath),
        .dmemload, .victim_data, .slot_data
    );

    dcache_bus_port u_bus (
        .addr        (req_addr),
        .victim_tag, .slot_tag, .victim_data, .slot_data,
        .dp          (ctl_if.datapath),
        .mem_addr, .mem_store
    );

    assign dhit = ctl_if.hit;

endmodule

`default_nettype wire

// File: logic/dcache_bus_port.sv
// memory addresses are always word aligned; the address reads zero when no operation runs
`default_nettype none

module dcache_bus_port import dcache_types_pkg::*, dcache_ctrl_pkg::*; (
    input  dc_addr_t         addr,
    input  dc_tag_t          victim_tag,
    input  dc_tag_t          slot_tag,
    input  word_t            victim_data,
    input  word_t            slot_data,
    dcache_ctrl_if.datapath  dp,
    output word_t            mem_addr,
    output word_t            mem_store
);

    dc_addr_t bus_addr;

    always_comb begin
        bus_addr         = '0;
        bus_addr.blk_off = dp.word_sel;
        case (dp.op)
            op_refill: begin
                bus_addr.tag = addr.tag;
                bus_addr.idx = addr.idx;
            end
            op_wb: begin
                bus_addr.tag = victim_tag;  // victim lives in the request's set
                bus_addr.idx = addr.idx;
            end
            op_flush: begin
                bus_addr.tag = slot_tag;
                bus_addr.idx = dp.flush_idx;
            end
            default: bus_addr.tag = '0;
        endcase
    end

    assign mem_addr  = word_t'(bus_addr);
    assign mem_store = (dp.op == op_flush) ? slot_data : victim_data;  // refill ignores it

endmodule

`default_nettype wire

// File: logic/dcache_control.sv
// a miss is served before halt when both arrive together; flushed holds until reset
`default_nettype none

module dcache_control import dcache_ctrl_pkg::*; (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            dmemren,
    input  logic            dmemwen,
    input  logic            halt,
    input  logic            mem_wait,
    dcache_ctrl_if.ctrl     ctl,
    output logic            mem_ren,
    output logic            mem_wen,
    output logic            flushed
);

    dc_state_t              state, next_state;
    logic [DC_SLOT_W-1:0]   slot_cnt, next_slot;  // {set, way} of the flush slot
    logic                   last_slot;
    logic                   commit;

    assign commit         = (mem_ren || mem_wen) && !mem_wait;
    assign last_slot      = (slot_cnt == DC_SLOT_W'(DC_SLOTS - 1));
    assign ctl.commit     = commit;
    assign ctl.flush_idx  = slot_cnt[DC_SLOT_W-1:1];
    assign ctl.flush_way  = slot_cnt[0];      // way is the low bit so both ways of a set go together
    assign flushed        = (state == s_flushed);

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= s_idle;
            slot_cnt <= '0;
        end else begin
            state    <= next_state;
            slot_cnt <= next_slot;
        end
    end

    always_comb begin
        next_state = state;
        next_slot  = slot_cnt;
        case (state)
            s_idle: begin
                if ((dmemren || dmemwen) && !ctl.hit) begin
                    next_state = ctl.victim_dirty ? s_wb0 : s_rf0;  // dirty victim goes out first
                end else if (halt) begin
                    next_state = s_fscan;
                    next_slot  = '0;
                end
            end
            s_wb0: next_state = commit ? s_wb1 : s_wb0;
            s_wb1: next_state = commit ? s_rf0 : s_wb1;
            s_rf0: next_state = commit ? s_rf1 : s_rf0;
            s_rf1: next_state = commit ? s_idle : s_rf1;
            s_fscan: begin
                if (ctl.slot_dirty) begin
                    next_state = s_fl0;
                end else if (last_slot) begin
                    next_state = s_flushed;
                end else begin
                    next_slot = slot_cnt + 1'b1;  // clean or empty slot costs one cycle
                end
            end
            s_fl0: next_state = commit ? s_fl1 : s_fl0;
            s_fl1: begin
                if (commit) begin
                    next_state = last_slot ? s_flushed : s_fscan;
                    next_slot  = slot_cnt + 1'b1;
                end
            end
            s_flushed: next_state = s_flushed;
            default: next_state = s_idle;
        endcase
    end

    always_comb begin
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        ctl.op  = op_none;
        case (state)
            s_wb0, s_wb1: begin
                mem_wen = 1'b1;
                ctl.op  = op_wb;
            end
            s_rf0, s_rf1: begin
                mem_ren = 1'b1;
                ctl.op  = op_refill;
            end
            s_fscan: ctl.op = op_flush;  // no strobe while deciding on a slot
            s_fl0, s_fl1: begin
                mem_wen = 1'b1;
                ctl.op  = op_flush;
            end
            default: ctl.op = op_none;
        endcase
        ctl.word_sel = (state == s_wb1) || (state == s_rf1) || (state == s_fl1);
    end

endmodule

`default_nettype wire

// File: logic/dcache_ctrl_if.sv
// only the tag array drives the datapath side; victim_way is the hit way whenever hit is high
`default_nettype none

interface dcache_ctrl_if import dcache_types_pkg::*, dcache_ctrl_pkg::*; ();

    bus_op_t op;            // bus operation in progress
    logic    word_sel;      // block word now on the bus
    dc_idx_t flush_idx;
    way_t    flush_way;
    logic    commit;        // memory finishes the current word at this edge

    logic    hit;
    logic    victim_dirty;
    logic    slot_dirty;    // flush slot is valid and dirty
    way_t    victim_way;

    modport ctrl (
        output op, word_sel, flush_idx, flush_way, commit,
        input  hit, victim_dirty, slot_dirty, victim_way
    );

    modport datapath (
        input  op, word_sel, flush_idx, flush_way, commit,
        output hit, victim_dirty, slot_dirty, victim_way
    );

endinterface

`default_nettype wire

// File: logic/dcache_ctrl_pkg.sv
// the flush walks every slot once, so the slot count must stay a power of two
`default_nettype none

`include "dcache_params.svh"

package dcache_ctrl_pkg;

    typedef enum logic [3:0] {
        s_idle, s_wb0, s_wb1, s_rf0, s_rf1, s_fscan, s_fl0, s_fl1, s_flushed
    } dc_state_t;

    typedef enum logic [1:0] {
        op_none, op_refill, op_wb, op_flush
    } bus_op_t;

    localparam int DC_SLOTS  = `DC_SETS * `DC_WAYS;  // blocks visited by a flush
    localparam int DC_SLOT_W = $clog2(DC_SLOTS);

endpackage

`default_nettype wire

// File: logic/dcache_data_array.sv
// reads are combinational; a pending store overrides the memory word it addresses during refill
`default_nettype none

`include "dcache_params.svh"

module dcache_data_array import dcache_types_pkg::*, dcache_ctrl_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  dc_addr_t         addr,
    input  logic             dmemwen,
    input  word_t            dmemstore,
    input  word_t            mem_load,
    dcache_ctrl_if.datapath  dp,
    output word_t            dmemload,
    output word_t            victim_data,
    output word_t            slot_data
);

    dc_block_t blocks [`DC_SETS][`DC_WAYS];
    word_t     fill_word;

    // store data wins over memory for the word the processor is writing
    assign fill_word = (dmemwen && (addr.blk_off == dp.word_sel)) ? dmemstore : mem_load;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            blocks <= '{default: '0};
        end else if ((dp.op == op_refill) && dp.commit) begin
            blocks[addr.idx][dp.victim_way][dp.word_sel] <= fill_word;
        end else if ((dp.op == op_none) && dp.hit && dmemwen) begin
            blocks[addr.idx][dp.victim_way][addr.blk_off] <= dmemstore;  // write hit
        end
    end

    assign dmemload    = blocks[addr.idx][dp.victim_way][addr.blk_off];
    assign victim_data = blocks[addr.idx][dp.victim_way][dp.word_sel];
    assign slot_data   = blocks[dp.flush_idx][dp.flush_way][dp.word_sel];

endmodule

`default_nettype wire

// File: logic/dcache_params.svh
// geometry is fixed at 2 ways of 2-word blocks; the tag width assumes 32-bit byte addresses
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DC_WORD_W      32  // data and address word width
`define DC_SETS        8
`define DC_IDX_W       3   // log2 of the set count
`define DC_WAYS        2
`define DC_BLK_WORDS   2
`define DC_TAG_W       26  // word width minus index, block word and byte offset
`define DC_BYTE_OFF_W  2

`endif

// File: logic/dcache_tag_array.sv
// written for exactly 2 ways with one LRU bit per set that names the way to evict next
`default_nettype none

`include "dcache_params.svh"

module dcache_tag_array import dcache_types_pkg::*, dcache_ctrl_pkg::*; (
    input  logic             CLK,
    input  logic             nRST,
    input  dc_addr_t         addr,
    input  logic             dmemren,
    input  logic             dmemwen,
    dcache_ctrl_if.datapath  dp,
    output dc_tag_t          victim_tag,
    output dc_tag_t          slot_tag
);

    dc_tag_t             tags  [`DC_SETS][`DC_WAYS];
    logic [`DC_WAYS-1:0] valid [`DC_SETS];
    logic [`DC_WAYS-1:0] dirty [`DC_SETS];
    logic [`DC_SETS-1:0] lru;          // set bit means way 1 is evicted next
    logic [`DC_WAYS-1:0] hit_vec;
    logic                hit;
    way_t                way;          // hit way on a hit, LRU victim otherwise
    logic                last_word;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_vec[w] = valid[addr.idx][w] && (tags[addr.idx][w] == addr.tag);
        end
    end

    assign hit             = |hit_vec;
    assign way             = hit ? way_t'(hit_vec[1]) : lru[addr.idx];
    assign last_word       = dp.commit && dp.word_sel;
    assign dp.hit          = hit;
    assign dp.victim_way   = way;
    assign dp.victim_dirty = valid[addr.idx][way] && dirty[addr.idx][way];
    assign dp.slot_dirty   = valid[dp.flush_idx][dp.flush_way] && dirty[dp.flush_idx][dp.flush_way];
    assign victim_tag      = tags[addr.idx][way];
    assign slot_tag        = tags[dp.flush_idx][dp.flush_way];

    // tag changes only once the whole block is in
    always_ff @(posedge CLK) begin
        if (last_word && (dp.op == op_refill)) begin
            tags[addr.idx][way] <= addr.tag;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            lru   <= '0;
        end else begin
            if ((dp.op == op_none) && hit && (dmemren || dmemwen)) begin
                lru[addr.idx] <= ~way;
                if (dmemwen) begin
                    dirty[addr.idx][way] <= 1'b1;
                end
            end
            if (last_word) begin
                case (dp.op)
                    op_refill: begin
                        valid[addr.idx][way] <= 1'b1;
                        dirty[addr.idx][way] <= dmemwen;  // merged store leaves the block dirty
                        lru[addr.idx]        <= ~way;
                    end
                    op_wb:    dirty[addr.idx][way] <= 1'b0;
                    op_flush: dirty[dp.flush_idx][dp.flush_way] <= 1'b0;
                    default:  ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/dcache_types_pkg.sv
// field widths come from dcache_params.svh; accesses are word aligned so byte_off is ignored
`default_nettype none

`include "dcache_params.svh"

package dcache_types_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_TAG_W-1:0] dc_tag_t;
    typedef logic [`DC_IDX_W-1:0] dc_idx_t;
    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

    // one cache block with word 0 in the low slot
    typedef logic [`DC_BLK_WORDS-1:0][`DC_WORD_W-1:0] dc_block_t;

    typedef struct packed {
        dc_tag_t                  tag;
        dc_idx_t                  idx;
        logic                     blk_off;   // word within the block
        logic [`DC_BYTE_OFF_W-1:0] byte_off;
    } dc_addr_t;

endpackage

`default_nettype wire

// File: verification/dcache_sva.sv
// bound to dcache_control; liveness of mem_wait is not checked, only strobe and flushed rules
`default_nettype none

module dcache_sva (
    input logic CLK,
    input logic nRST,
    input logic mem_ren,
    input logic mem_wen,
    input logic mem_wait,
    input logic flushed
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // failed assertions so far

    one_strobe: assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
        else begin
            fail_count++;
            $error("read and write strobes are high together");
        end

    read_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren && mem_wait) |=> mem_ren)
        else begin
            fail_count++;
            $error("read strobe dropped while memory was waiting");
        end

    write_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_wen && mem_wait) |=> mem_wen)
        else begin
            fail_count++;
            $error("write strobe dropped while memory was waiting");
        end

    // flushed is a level that only reset clears
    flushed_stays: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
        else begin
            fail_count++;
            $error("flushed fell without a reset");
        end

    quiet_after_flush: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |-> (!mem_ren && !mem_wen))
        else begin
            fail_count++;
            $error("bus strobe seen after flushed");
        end

endmodule

`default_nettype wire

// File: verification/dcache_tb.sv
// tests stay in a 64-word window (4 tags x 8 sets x 2 words); memory answers within 3 wait cycles
`default_nettype none

`include "dcache_params.svh"

module dcache_tb import dcache_types_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RANDOM       = 200;
    localparam int WINDOW         = 4 * `DC_SETS * `DC_BLK_WORDS;  // words the tests can reach
    localparam int TIMEOUT_CYCLES = (N_RANDOM + 12) * 20 + 16 * 10 + 20;

    logic        CLK = 1'b0;
    logic        nRST, dmemren, dmemwen, halt, mem_wait, dhit, flushed, mem_ren, mem_wen;
    word_t       dmemaddr, dmemstore, mem_load, dmemload, mem_addr, mem_store;
    word_t       mem_model  [WINDOW];
    word_t       flat_model [WINDOW];
    logic        bus_we   [$];  // one entry per finished bus word
    logic [5:0]  bus_word [$];
    logic [15:0] stim_lfsr = 16'd85;
    logic [15:0] wait_lfsr = 16'd85;
    int          wait_left = -1;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    dcache dut0 (.*);

    bind dcache_control dcache_sva sva0 (.CLK, .nRST, .mem_ren, .mem_wen, .mem_wait, .flushed);

    always #4 CLK = ~CLK;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    function automatic word_t take_bits(inout logic [15:0] s, input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_step(s);
            v = {v[30:0], s[0]};
        end
        return v;
    endfunction

    function automatic logic [5:0] word_at(input int tag, input int set, input int off);
        return {2'(tag), 3'(set), 1'(off)};  // word index is address bits 7 to 2
    endfunction

    // memory model that decides each word's wait cycles when the word starts
    always @(posedge CLK) begin
        #1;
        if (!(mem_ren || mem_wen)) begin
            mem_wait  = 1'b1;
            wait_left = -1;
        end else begin
            if (wait_left < 0) begin
                wait_left = int'(take_bits(wait_lfsr, 2));
            end
            if ((mem_addr[31:8] != '0) || (mem_addr[1:0] != 2'b00)) begin
                $display("ERROR at %0t: bus address %h is outside the test window", $time,
                         mem_addr);
                errors++;
            end
            if (wait_left == 0) begin
                mem_wait = 1'b0;
                mem_load = mem_model[mem_addr[7:2]];
                if (mem_wen) begin
                    mem_model[mem_addr[7:2]] = mem_store;
                end
                bus_we.push_back(mem_wen);
                bus_word.push_back(mem_addr[7:2]);
                wait_left = -1;
            end else begin
                mem_wait = 1'b1;
                wait_left--;
            end
        end
    end

    task automatic cache_access(input logic wr, input logic [5:0] word, input word_t data,
                                output word_t rd, output int waited);
        @(posedge CLK);
        #1;
        dmemren   = !wr;
        dmemwen   = wr;
        dmemaddr  = {24'd0, word, 2'b00};
        dmemstore = data;
        waited    = 0;
        @(negedge CLK);
        while (!dhit) begin
            waited++;
            @(negedge CLK);
        end
        rd = dmemload;
        @(posedge CLK);
        #1;
        dmemren = 1'b0;
        dmemwen = 1'b0;
        if (wr) begin
            flat_model[word] = data;
        end
    endtask

    task automatic read_and_check(input logic [5:0] word, output int waited);
        word_t got;
        cache_access(1'b0, word, '0, got, waited);
        if (got !== flat_model[word]) begin
            $display("MISMATCH at %0t: word %0d read %h, expected %h", $time, word, got,
                     flat_model[word]);
            errors++;
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        int    waited;
        word_t rd;
        word_t d;
        logic  wr;
        logic [5:0] w;
        nRST      = 1'b0;
        dmemren   = 1'b0;
        dmemwen   = 1'b0;
        halt      = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        mem_load  = '0;
        mem_wait  = 1'b1;
        for (int i = 0; i < WINDOW; i++) begin
            mem_model[i]  = 32'hC0DE0000 ^ (i * 32'h00010101);  // every address bit shows
            flat_model[i] = mem_model[i];
        end
        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;

        @(negedge CLK);
        if (mem_ren || mem_wen || flushed || dhit) begin
            $display("ERROR at %0t: outputs not low after reset", $time);
            errors++;
        end
        close_test("reset state");

        bus_we.delete();
        bus_word.delete();
        read_and_check(word_at(0, 0, 1), waited);
        if ((bus_word.size() != 2) || (waited == 0)) begin
            $display("ERROR at %0t: clean miss used %0d bus words", $time, bus_word.size());
            errors++;
        end else if (bus_we[0] || bus_we[1] || (bus_word[0] != word_at(0, 0, 0))
                     || (bus_word[1] != word_at(0, 0, 1))) begin
            $display("MISMATCH at %0t: clean miss bus words %0d, %0d are wrong", $time,
                     bus_word[0], bus_word[1]);
            errors++;
        end
        close_test("clean miss refill");

        read_and_check(word_at(0, 3, 0), waited);
        read_and_check(word_at(1, 3, 0), waited);
        read_and_check(word_at(0, 3, 0), waited);
        read_and_check(word_at(2, 3, 0), waited);  // evicts B as the least recent
        bus_word.delete();
        bus_we.delete();
        read_and_check(word_at(0, 3, 1), waited);
        if ((waited != 0) || (bus_word.size() != 0)) begin
            $display("ERROR at %0t: recently used block was evicted", $time);
            errors++;
        end
        close_test("lru victim");

        cache_access(1'b1, word_at(0, 5, 0), take_bits(stim_lfsr, 32), rd, waited);
        cache_access(1'b1, word_at(0, 5, 1), take_bits(stim_lfsr, 32), rd, waited);
        cache_access(1'b1, word_at(1, 5, 1), take_bits(stim_lfsr, 32), rd, waited);
        bus_word.delete();
        bus_we.delete();
        read_and_check(word_at(2, 5, 0), waited);
        if (bus_word.size() != 4) begin
            $display("ERROR at %0t: dirty miss used %0d bus words", $time, bus_word.size());
            errors++;
        end else if (!bus_we[0] || !bus_we[1] || bus_we[2] || bus_we[3]
                     || (bus_word[0] != word_at(0, 5, 0)) || (bus_word[1] != word_at(0, 5, 1))
                     || (bus_word[2] != word_at(2, 5, 0))
                     || (bus_word[3] != word_at(2, 5, 1))) begin
            $display("MISMATCH at %0t: dirty miss bus order or addresses wrong", $time);
            errors++;
        end
        for (int off = 0; off < 2; off++) begin
            if (mem_model[word_at(0, 5, off)] !== flat_model[word_at(0, 5, off)]) begin
                $display("MISMATCH at %0t: written back word %0d holds %h", $time,
                         word_at(0, 5, off), mem_model[word_at(0, 5, off)]);
                errors++;
            end
        end
        close_test("dirty eviction");

        for (int n = 0; n < N_RANDOM; n++) begin
            wr = 1'(take_bits(stim_lfsr, 1));
            w  = 6'(take_bits(stim_lfsr, 6));
            if (wr) begin
                d = take_bits(stim_lfsr, 32);
                cache_access(1'b1, w, d, rd, waited);
            end else begin
                read_and_check(w, waited);
            end
        end
        close_test("random access");

        @(posedge CLK);
        #1;
        halt = 1'b1;
        @(negedge CLK);
        while (!flushed) begin
            @(negedge CLK);
        end
        for (int i = 0; i < WINDOW; i++) begin
            if (mem_model[i] !== flat_model[i]) begin
                $display("MISMATCH at %0t: memory word %0d is %h after flush, expected %h",
                         $time, i, mem_model[i], flat_model[i]);
                errors++;
            end
        end
        bus_word.delete();
        repeat (10) @(negedge CLK);
        if ((bus_word.size() != 0) || mem_ren || mem_wen) begin
            $display("ERROR at %0t: bus strobe seen after flushed", $time);
            errors++;
        end
        close_test("flush on halt");

        errors = errors + dut0.u_control.sva0.fail_count;
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("ERROR: run did not finish in %0d cycles, the cache stopped responding",
                 TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
